//--- Makefile
SIM := obj_dir/Vdebug_io_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

$(SIM): build.f $(shell cat build.f)
	verilator --binary --assert --timing --top-module debug_io_tb -Mdir obj_dir -f build.f

clean:
	rm -rf obj_dir

//--- build.f
design/debug_io_pkg.sv
design/input_sync.sv
design/input_debounce.sv
design/event_capture.sv
design/axil_regs.sv
design/debug_io_top.sv
tb/debug_io_props.sv
tb/debug_io_tb.sv

//--- design/axil_regs.sv
`timescale 1ns/1ps

module axil_regs (
   input  logic                     wb,
   input  logic                     rst_n,
   input  debug_io_pkg::axil_req_t  req,
   output debug_io_pkg::axil_rsp_t  rsp,
   input  debug_io_pkg::in_sample_t level,
   input  debug_io_pkg::in_sample_t events,
   output debug_io_pkg::in_sample_t mask,
   output debug_io_pkg::in_sample_t clear
);

   localparam int pad_width = debug_io_pkg::data_width - debug_io_pkg::in_width;

   debug_io_pkg::reg_addr_e           wr_addr;
   debug_io_pkg::reg_addr_e           rd_addr;
   logic                              wr_go;
   logic                              rd_go;
   logic                              b_valid;
   logic                              r_valid;
   debug_io_pkg::axil_resp_e          b_resp;
   debug_io_pkg::axil_resp_e          r_resp;
   logic [debug_io_pkg::data_width-1:0] r_data;
   logic [debug_io_pkg::in_width-1:0] wr_byte;

   assign wr_addr = debug_io_pkg::reg_addr_e'(req.aw_addr);
   assign rd_addr = debug_io_pkg::reg_addr_e'(req.ar_addr);
   assign wr_byte = req.w_data[debug_io_pkg::in_width-1:0];

   // address and data are taken together, one write in flight
   assign wr_go = req.aw_valid && req.w_valid && !b_valid;
   assign rd_go = req.ar_valid && !r_valid;

   assign rsp.aw_ready = wr_go;
   assign rsp.w_ready  = wr_go;
   assign rsp.b_valid  = b_valid;
   assign rsp.b_resp   = b_resp;
   assign rsp.ar_ready = rd_go;
   assign rsp.r_valid  = r_valid;
   assign rsp.r_resp   = r_resp;
   assign rsp.r_data   = r_data;

   always_ff @(posedge wb or negedge rst_n) begin
      if (!rst_n) begin
         b_valid <= 1'b0;
         r_valid <= 1'b0;
         mask    <= '0;
         clear   <= '0;
      end else begin
         // clear is a single-cycle pulse
         clear <= '0;
         if (wr_go) begin
            b_valid <= 1'b1;
            if (req.w_strb[0]) begin
               case (wr_addr)
                  debug_io_pkg::reg_event: clear <= wr_byte;
                  debug_io_pkg::reg_mask:  mask  <= wr_byte;
                  default: ;
               endcase
            end
         end else if (b_valid && req.b_ready) begin
            b_valid <= 1'b0;
         end
         if (rd_go) begin
            r_valid <= 1'b1;
         end else if (r_valid && req.r_ready) begin
            r_valid <= 1'b0;
         end
      end
   end

   // response payload, only loaded on acceptance
   always_ff @(posedge wb) begin
      if (wr_go) begin
         case (wr_addr)
            debug_io_pkg::reg_event,
            debug_io_pkg::reg_mask:  b_resp <= debug_io_pkg::resp_okay;
            // level is read only
            default:                 b_resp <= debug_io_pkg::resp_slverr;
         endcase
      end
      if (rd_go) begin
         r_resp <= debug_io_pkg::resp_okay;
         case (rd_addr)
            debug_io_pkg::reg_level: r_data <= {{pad_width{1'b0}}, level};
            debug_io_pkg::reg_event: r_data <= {{pad_width{1'b0}}, events};
            debug_io_pkg::reg_mask:  r_data <= {{pad_width{1'b0}}, mask};
            default: begin
               r_data <= '0;
               r_resp <= debug_io_pkg::resp_slverr;
            end
         endcase
      end
   end

endmodule

//--- design/debug_io_pkg.sv
package debug_io_pkg;

   // sampled input count and bus widths
   localparam int in_width   = 8;
   localparam int addr_width = 4;
   localparam int data_width = 32;

   // one sample of the debug inputs, switches in the upper half
   typedef struct packed {
      logic [in_width/2-1:0] switches;
      logic [in_width/2-1:0] buttons;
   } in_sample_t;

   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } axil_resp_e;

   // register map, byte addresses
   typedef enum logic [addr_width-1:0] {
      reg_level = 4'h0,
      reg_event = 4'h4,
      reg_mask  = 4'h8
   } reg_addr_e;

   // signals driven by the AXI4-Lite master
   typedef struct packed {
      logic [addr_width-1:0]   aw_addr;
      logic                    aw_valid;
      logic [data_width-1:0]   w_data;
      logic [data_width/8-1:0] w_strb;
      logic                    w_valid;
      logic                    b_ready;
      logic [addr_width-1:0]   ar_addr;
      logic                    ar_valid;
      logic                    r_ready;
   } axil_req_t;

   // signals driven by the AXI4-Lite slave
   typedef struct packed {
      logic                  aw_ready;
      logic                  w_ready;
      axil_resp_e            b_resp;
      logic                  b_valid;
      logic                  ar_ready;
      logic [data_width-1:0] r_data;
      axil_resp_e            r_resp;
      logic                  r_valid;
   } axil_rsp_t;

endpackage

//--- design/debug_io_top.sv
`timescale 1ns/1ps

module debug_io_top #(
   parameter int DEBOUNCE_PERIOD = 5
) (
   input  logic                    wb,
   input  logic                    rst_n,
   input  logic [3:0]              buttons,
   input  logic [3:0]              switches,
   input  debug_io_pkg::axil_req_t req,
   output debug_io_pkg::axil_rsp_t rsp,
   output logic                    irq
);

   debug_io_pkg::in_sample_t sync_sample;
   debug_io_pkg::in_sample_t stable_sample;
   debug_io_pkg::in_sample_t level;
   debug_io_pkg::in_sample_t events;
   debug_io_pkg::in_sample_t mask;
   debug_io_pkg::in_sample_t clear;

   input_sync input_sync_i (
      .wb          (wb),
      .rst_n       (rst_n),
      .buttons     (buttons),
      .switches    (switches),
      .sync_sample (sync_sample)
   );

   input_debounce #(
      .DEBOUNCE_PERIOD (DEBOUNCE_PERIOD)
   ) input_debounce_i (
      .wb            (wb),
      .rst_n         (rst_n),
      .sync_sample   (sync_sample),
      .stable_sample (stable_sample)
   );

   event_capture event_capture_i (
      .wb            (wb),
      .rst_n         (rst_n),
      .stable_sample (stable_sample),
      .mask          (mask),
      .clear         (clear),
      .level         (level),
      .events        (events),
      .irq           (irq)
   );

   // register slave, feeds mask and clear back to the event stage
   axil_regs axil_regs_i (
      .wb     (wb),
      .rst_n  (rst_n),
      .req    (req),
      .rsp    (rsp),
      .level  (level),
      .events (events),
      .mask   (mask),
      .clear  (clear)
   );

endmodule

//--- design/event_capture.sv
`timescale 1ns/1ps

module event_capture (
   input  logic                     wb,
   input  logic                     rst_n,
   input  debug_io_pkg::in_sample_t stable_sample,
   input  debug_io_pkg::in_sample_t mask,
   input  debug_io_pkg::in_sample_t clear,
   output debug_io_pkg::in_sample_t level,
   output debug_io_pkg::in_sample_t events,
   output logic                     irq
);

   debug_io_pkg::in_sample_t prev_sample;
   debug_io_pkg::in_sample_t rise;

   assign level = stable_sample;
   assign rise  = stable_sample & ~prev_sample;

   always_ff @(posedge wb or negedge rst_n) begin
      if (!rst_n) begin
         prev_sample <= '0;
         events      <= '0;
         irq         <= 1'b0;
      end else begin
         prev_sample <= stable_sample;
         // clear first, so a fresh edge in the same cycle survives
         events      <= (events & ~clear) | rise;
         // lags the flags and mask by one cycle
         irq         <= |(events & mask);
      end
   end

endmodule

//--- design/input_debounce.sv
`timescale 1ns/1ps

module input_debounce #(
   parameter int DEBOUNCE_PERIOD = 5
) (
   input  logic                     wb,
   input  logic                     rst_n,
   input  debug_io_pkg::in_sample_t sync_sample,
   output debug_io_pkg::in_sample_t stable_sample
);

   logic [31:0]                       count;
   logic [debug_io_pkg::in_width-1:0] candidate;
   logic                              start;
   logic                              window_end;

   // a window opens only while idle and the input differs from the accepted value
   assign start      = (count == 32'd0) && (sync_sample != stable_sample);
   assign window_end = (count == 32'(DEBOUNCE_PERIOD));

   always_ff @(posedge wb or negedge rst_n) begin
      if (!rst_n) begin
         count         <= '0;
         stable_sample <= '0;
      end else if (window_end) begin
         count <= '0;
         // adopt only if the input is back at the candidate value
         if (sync_sample == candidate) begin
            stable_sample <= candidate;
         end
      end else if (count != 32'd0) begin
         count <= count + 32'd1;
      end else if (start) begin
         count <= 32'd1;
      end
   end

   // whole vector snapshot at the start of the window
   always_ff @(posedge wb) begin
      if (start) begin
         candidate <= sync_sample;
      end
   end

endmodule

//--- design/input_sync.sv
`timescale 1ns/1ps

module input_sync (
   input  logic                   wb,
   input  logic                   rst_n,
   input  logic [3:0]             buttons,
   input  logic [3:0]             switches,
   output debug_io_pkg::in_sample_t sync_sample
);

   debug_io_pkg::in_sample_t raw_sample;
   // first rank may go metastable, only the second is used downstream
   logic [debug_io_pkg::in_width-1:0] meta;

   assign raw_sample.switches = switches;
   assign raw_sample.buttons  = buttons;

   always_ff @(posedge wb or negedge rst_n) begin
      if (!rst_n) begin
         meta        <= '0;
         sync_sample <= '0;
      end else begin
         meta        <= raw_sample;
         sync_sample <= meta;
      end
   end

endmodule

//--- tb/debug_io_props.sv
`timescale 1ns/1ps

module debug_io_props (
   input logic                    wb,
   input logic                    rst_n,
   input debug_io_pkg::axil_req_t req,
   input debug_io_pkg::axil_rsp_t rsp
);

   // a read response stays up until the master takes it
   r_valid_held: assert property (@(posedge wb) disable iff (!rst_n)
      rsp.r_valid && !req.r_ready |=> rsp.r_valid)
      else $error("r_valid dropped before r_ready was seen");

   b_valid_held: assert property (@(posedge wb) disable iff (!rst_n)
      rsp.b_valid && !req.b_ready |=> rsp.b_valid)
      else $error("b_valid dropped before b_ready was seen");

   // read data frozen while the master stalls
   r_data_stable: assert property (@(posedge wb) disable iff (!rst_n)
      rsp.r_valid && !req.r_ready |=> $stable(rsp.r_data))
      else $error("r_data changed while waiting for r_ready");

   // address and data are only ever taken together, then the response follows
   aw_with_w: assert property (@(posedge wb) disable iff (!rst_n)
      $rose(rsp.b_valid) |-> $past(rsp.aw_ready && rsp.w_ready))
      else $error("write response without address and data accepted together");

   // a read response only follows an accepted address
   ar_before_r: assert property (@(posedge wb) disable iff (!rst_n)
      $rose(rsp.r_valid) |-> $past(rsp.ar_ready))
      else $error("read response without an accepted read address");

endmodule

//--- tb/debug_io_tb.sv
`timescale 1ns/1ps

module debug_io_tb;

   localparam int debounce_period = 8;
   localparam int settle_cycles   = 2 * debounce_period + 6;
   localparam int num_vectors     = 40;
   localparam int num_glitches    = 10;
   localparam int handshake_limit = 16;
   // worst case bus operation: acceptance wait, stall and handshake
   localparam int op_cycles       = handshake_limit + 6;
   localparam int run_cycles      = 16 + 8 * op_cycles
      + num_vectors * (settle_cycles + 8 * op_cycles + 2)
      + num_glitches * (settle_cycles + debounce_period + 3 * op_cycles);

   logic                    wb;
   logic                    rst_n;
   logic [3:0]              buttons;
   logic [3:0]              switches;
   debug_io_pkg::axil_req_t req;
   debug_io_pkg::axil_rsp_t rsp;
   logic                    irq;

   integer seed = 15;
   int     mismatch_count = 0;
   int     failure_count  = 0;

   // reference model, updated only at settled points
   logic [7:0] model_level;
   logic [7:0] model_events;
   logic [7:0] model_mask;

   debug_io_top #(
      .DEBOUNCE_PERIOD (debounce_period)
   ) debug_io_top_i (
      .wb       (wb),
      .rst_n    (rst_n),
      .buttons  (buttons),
      .switches (switches),
      .req      (req),
      .rsp      (rsp),
      .irq      (irq)
   );

   bind axil_regs debug_io_props props_i (.wb(wb), .rst_n(rst_n), .req(req), .rsp(rsp));

   initial begin
      wb = 1'b0;
      forever #2 wb = ~wb;
   end

   initial begin
      repeat (run_cycles + 200) @(posedge wb);
      $display("watchdog expired after %0d cycles, the test did not finish", run_cycles + 200);
      $display(">>> FAIL");
      $finish;
   end

   function automatic void expect_equal(input string what, input logic [31:0] got,
                                        input logic [31:0] exp);
      assert (got === exp) else begin
         mismatch_count++;
         $display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endfunction

   task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
                            output debug_io_pkg::axil_resp_e resp);
      int waited;
      int stall;
      waited = 0;
      stall  = $random(seed) & 3;
      @(negedge wb);
      req.aw_addr  = addr;
      req.w_data   = data;
      req.w_strb   = 4'hf;
      req.aw_valid = 1'b1;
      req.w_valid  = 1'b1;
      // b_valid rising marks the edge where address and data were taken
      do begin
         @(negedge wb);
         waited++;
      end while (!rsp.b_valid && waited < handshake_limit);
      req.aw_valid = 1'b0;
      req.w_valid  = 1'b0;
      assert (rsp.b_valid) else begin
         failure_count++;
         $display("write to 0x%0h was not answered within %0d cycles", addr, handshake_limit);
      end
      repeat (stall) @(negedge wb);
      resp        = rsp.b_resp;
      req.b_ready = 1'b1;
      @(negedge wb);
      req.b_ready = 1'b0;
   endtask

   task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
                           output debug_io_pkg::axil_resp_e resp);
      int waited;
      int stall;
      waited = 0;
      stall  = $random(seed) & 3;
      @(negedge wb);
      req.ar_addr  = addr;
      req.ar_valid = 1'b1;
      do begin
         @(negedge wb);
         waited++;
      end while (!rsp.r_valid && waited < handshake_limit);
      req.ar_valid = 1'b0;
      assert (rsp.r_valid) else begin
         failure_count++;
         $display("read of 0x%0h was not answered within %0d cycles", addr, handshake_limit);
      end
      // data is taken at the end of the stall, so it must have held
      repeat (stall) @(negedge wb);
      data        = rsp.r_data;
      resp        = rsp.r_resp;
      req.r_ready = 1'b1;
      @(negedge wb);
      req.r_ready = 1'b0;
   endtask

   // called on a falling edge, holds the value for exactly the given cycles
   task automatic apply_inputs(input logic [7:0] value, input int cycles);
      switches = value[7:4];
      buttons  = value[3:0];
      repeat (cycles) @(negedge wb);
   endtask

   task automatic check_regs;
      logic [31:0]              data;
      debug_io_pkg::axil_resp_e resp;
      read_reg(debug_io_pkg::reg_level, data, resp);
      expect_equal("reg_level", data, {24'h0, model_level});
      expect_equal("reg_level response", 32'(resp), 32'(debug_io_pkg::resp_okay));
      read_reg(debug_io_pkg::reg_event, data, resp);
      expect_equal("reg_event", data, {24'h0, model_events});
      expect_equal("reg_event response", 32'(resp), 32'(debug_io_pkg::resp_okay));
      read_reg(debug_io_pkg::reg_mask, data, resp);
      expect_equal("reg_mask", data, {24'h0, model_mask});
      expect_equal("reg_mask response", 32'(resp), 32'(debug_io_pkg::resp_okay));
      expect_equal("irq", 32'(irq), 32'(|(model_events & model_mask)));
   endtask

   initial begin
      logic [3:0]               sw;
      logic [3:0]               bt;
      logic [7:0]               value;
      logic [31:0]              data;
      debug_io_pkg::axil_resp_e resp;
      int                       glitch_len;
      rst_n        = 1'b0;
      buttons      = 4'h0;
      switches     = 4'h0;
      req          = '0;
      model_level  = 8'h00;
      model_events = 8'h00;
      model_mask   = 8'h00;
      repeat (16) @(negedge wb);
      rst_n = 1'b1;
      check_regs();

      for (int i = 0; i < num_vectors; i++) begin
         sw = 4'($random(seed));
         bt = 4'($random(seed));
         apply_inputs({sw, bt}, settle_cycles);
         // one debounced step from the old level, so one set of rising edges
         model_events = model_events | ({sw, bt} & ~model_level);
         model_level  = {sw, bt};
         check_regs();
         value = 8'($random(seed));
         write_reg(debug_io_pkg::reg_event, {24'h0, value}, resp);
         expect_equal("reg_event write response", 32'(resp), 32'(debug_io_pkg::resp_okay));
         model_events = model_events & ~value;
         if ($random(seed) & 1) begin
            value = 8'($random(seed));
            write_reg(debug_io_pkg::reg_mask, {24'h0, value}, resp);
            expect_equal("reg_mask write response", 32'(resp), 32'(debug_io_pkg::resp_okay));
            model_mask = value;
         end
         check_regs();
      end

      // short pulses must not get through the debouncer
      for (int i = 0; i < num_glitches; i++) begin
         value      = 8'($random(seed)) | 8'h01;
         glitch_len = 1 + int'({$random(seed)} % (debounce_period - 3));
         apply_inputs(model_level ^ value, glitch_len);
         apply_inputs(model_level, settle_cycles);
         check_regs();
      end

      read_reg(4'hC, data, resp);
      expect_equal("unmapped read data", data, 32'h0);
      expect_equal("unmapped read response", 32'(resp), 32'(debug_io_pkg::resp_slverr));
      write_reg(debug_io_pkg::reg_level, 32'(~model_level), resp);
      expect_equal("reg_level write response", 32'(resp), 32'(debug_io_pkg::resp_slverr));
      check_regs();

      $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
